// File: rtl/rt_num_pkg.sv
package rt_num_pkg;

  // Signed Q8.8 scalar
  typedef logic signed [15:0] fx_t;

  localparam int FRAC_BITS = 8;

  // 1.0 in Q8.8
  localparam fx_t FX_ONE = 16'sd256;

  typedef struct packed {
    fx_t x;
    fx_t y;
    fx_t z;
  } vec3_t;

  // Channel value 1.0 is full intensity
  typedef struct packed {
    fx_t r;
    fx_t g;
    fx_t b;
  } color_t;

  // Full-width product scaled back to Q8.8, wraps on overflow
  function automatic fx_t fx_mul(fx_t a, fx_t b);
    logic signed [31:0] p;
    p = a * b;
    return fx_t'(p >>> FRAC_BITS);
  endfunction

endpackage

// File: rtl/rt_scene_pkg.sv
package rt_scene_pkg;

  // Normal axis of a mirror plane
  typedef enum logic [1:0] {
    AXIS_X,
    AXIS_Y,
    AXIS_Z
  } axis_e;

  typedef struct packed {
    rt_num_pkg::color_t albedo;
    rt_num_pkg::color_t emission;
  } material_t;

  // Plane at coordinate pos along axis
  typedef struct packed {
    axis_e axis;
    rt_num_pkg::fx_t pos;
    material_t mat;
  } object_t;

  // Component of v along the plane axis
  function automatic rt_num_pkg::fx_t vec_axis(rt_num_pkg::vec3_t v, axis_e a);
    case (a)
      AXIS_X: return v.x;
      AXIS_Y: return v.y;
      default: return v.z;
    endcase
  endfunction

endpackage

// File: rtl/rt_ifs.sv
`timescale 1ns/1ps

// Ray issue and completion between generator and tracer
interface ray_if;
  rt_num_pkg::vec3_t origin;
  rt_num_pkg::vec3_t dir;
  logic ray_valid;
  logic ray_done;
  rt_num_pkg::color_t color;

  modport gen (
    output origin, dir, ray_valid,
    input ray_done, color
  );

  modport tracer (
    input origin, dir, ray_valid,
    output ray_done, color
  );
endinterface

// Indexed object read port, data one cycle after obj_idx
interface scene_if #(
  parameter int SCENE_DEPTH = 8
);
  logic [$clog2(SCENE_DEPTH)-1:0] obj_idx;
  rt_scene_pkg::object_t obj;
  logic obj_last;
  logic scene_empty;

  modport reader (output obj_idx, input obj, obj_last, scene_empty);

  modport mem (input obj_idx, output obj, obj_last, scene_empty);
endinterface

// File: rtl/scene_buffer.sv
`timescale 1ns/1ps

module scene_buffer #(
  parameter int SCENE_DEPTH = 8
) (
  input  logic clk,
  input  logic rst,
  input  logic load_we,
  input  logic [$clog2(SCENE_DEPTH)-1:0] load_idx,
  input  logic load_last,
  input  rt_scene_pkg::object_t load_obj,
  scene_if.mem scene
);

  rt_scene_pkg::object_t mem [SCENE_DEPTH];

  logic [$clog2(SCENE_DEPTH)-1:0] last_idx;
  logic loaded;

  // Object storage with registered read
  always_ff @(posedge clk) begin
    if (load_we) begin
      mem[load_idx] <= load_obj;
    end
    scene.obj <= mem[scene.obj_idx];
  end

  // Scene counts as loaded once the final entry is written
  always_ff @(posedge clk) begin
    if (rst) begin
      loaded   <= 1'b0;
      last_idx <= '0;
    end else if (load_we && load_last) begin
      loaded   <= 1'b1;
      last_idx <= load_idx;
    end
  end

  assign scene.obj_last    = loaded && (scene.obj_idx == last_idx);
  assign scene.scene_empty = !loaded;

endmodule

// File: rtl/pixel_ray_gen.sv
`timescale 1ns/1ps

module pixel_ray_gen #(
  parameter int WIDTH  = 8,
  parameter int HEIGHT = 6,
  parameter int FOCAL  = 4
) (
  input  logic clk,
  input  logic rst,
  input  logic start,
  ray_if.gen ray,
  output logic pix_valid,
  output logic [$clog2(WIDTH)-1:0] pix_h,
  output logic [$clog2(HEIGHT)-1:0] pix_v,
  output rt_num_pkg::color_t pix_color,
  output logic frame_done
);

  typedef enum logic [1:0] {GEN_IDLE, GEN_ISSUE, GEN_WAIT} gen_state;

  gen_state state;
  logic [$clog2(WIDTH)-1:0] h;
  logic [$clog2(HEIGHT)-1:0] v;
  int dx;
  int dy;
  logic last_h;
  logic last_v;

  // Camera at origin looking down +z, pixel grid centered on axis
  always_comb begin
    dx = int'(h) - WIDTH / 2;
    dy = int'(v) - HEIGHT / 2;
    ray.origin = '0;
    ray.dir.x  = rt_num_pkg::fx_t'(dx <<< rt_num_pkg::FRAC_BITS);
    ray.dir.y  = rt_num_pkg::fx_t'(dy <<< rt_num_pkg::FRAC_BITS);
    ray.dir.z  = rt_num_pkg::fx_t'(FOCAL <<< rt_num_pkg::FRAC_BITS);
  end

  assign ray.ray_valid = (state == GEN_ISSUE);
  assign last_h = (h == WIDTH - 1);
  assign last_v = (v == HEIGHT - 1);

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= GEN_IDLE;
      h          <= '0;
      v          <= '0;
      pix_valid  <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      pix_valid  <= 1'b0;
      frame_done <= 1'b0;
      case (state)
        GEN_IDLE: begin
          if (start) begin
            h     <= '0;
            v     <= '0;
            state <= GEN_ISSUE;
          end
        end
        GEN_ISSUE: state <= GEN_WAIT;
        GEN_WAIT: begin
          if (ray.ray_done) begin
            pix_valid <= 1'b1;
            // Raster order, h steps fastest
            if (!last_h) begin
              h     <= h + 1'b1;
              state <= GEN_ISSUE;
            end else if (!last_v) begin
              h     <= '0;
              v     <= v + 1'b1;
              state <= GEN_ISSUE;
            end else begin
              frame_done <= 1'b1;
              state      <= GEN_IDLE;
            end
          end
        end
        default: state <= GEN_IDLE;
      endcase
    end
  end

  // Finished pixel with its coordinates
  always_ff @(posedge clk) begin
    if (state == GEN_WAIT && ray.ray_done) begin
      pix_h     <= h;
      pix_v     <= v;
      pix_color <= ray.color;
    end
  end

endmodule

// File: rtl/ray_intersector.sv
`timescale 1ns/1ps

module ray_intersector #(
  parameter int SCENE_DEPTH = 8
) (
  input  logic clk,
  input  logic rst,
  input  rt_num_pkg::vec3_t ray_origin,
  input  rt_num_pkg::vec3_t ray_dir,
  input  logic ray_valid,
  output rt_num_pkg::vec3_t hit_pos,
  output rt_scene_pkg::axis_e hit_axis,
  output rt_scene_pkg::material_t hit_mat,
  output logic hit_any,
  output logic hit_valid,
  scene_if.reader scene
);

  typedef enum logic [2:0] {IDLE, FETCH, DIVIDE, COMPARE, FINISH} isect_state;

  isect_state state;

  // Restoring divider
  logic [4:0] div_cnt;
  logic [15:0] rem;
  logic [15:0] quo;
  logic [15:0] den;
  logic div_neg;
  logic div_ok;

  rt_num_pkg::fx_t org_ax;
  rt_num_pkg::fx_t dir_ax;
  logic signed [16:0] diff;
  logic [24:0] num_abs;
  logic [15:0] den_abs;
  logic [16:0] trial;
  logic t_hit;

  // Nearest hit so far
  logic best_valid;
  rt_num_pkg::fx_t best_t;
  rt_scene_pkg::axis_e best_axis;
  rt_num_pkg::fx_t best_plane;
  rt_scene_pkg::material_t best_mat;
  rt_num_pkg::vec3_t pos_calc;

  always_comb begin
    org_ax  = rt_scene_pkg::vec_axis(ray_origin, scene.obj.axis);
    dir_ax  = rt_scene_pkg::vec_axis(ray_dir, scene.obj.axis);
    diff    = scene.obj.pos - org_ax;
    num_abs = diff[16] ? -{diff, 8'b0} : {diff, 8'b0};
    den_abs = dir_ax[15] ? -dir_ax : dir_ax;
    trial   = {rem, quo[15]};
    // Positive t that fits in Q8.8
    t_hit   = div_ok && !div_neg && (quo != 16'd0) && !quo[15];
  end

  // Hit point, exact on the plane axis
  always_comb begin
    pos_calc.x = ray_origin.x + rt_num_pkg::fx_mul(best_t, ray_dir.x);
    pos_calc.y = ray_origin.y + rt_num_pkg::fx_mul(best_t, ray_dir.y);
    pos_calc.z = ray_origin.z + rt_num_pkg::fx_mul(best_t, ray_dir.z);
    case (best_axis)
      rt_scene_pkg::AXIS_X: pos_calc.x = best_plane;
      rt_scene_pkg::AXIS_Y: pos_calc.y = best_plane;
      default: pos_calc.z = best_plane;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= IDLE;
      hit_valid     <= 1'b0;
      hit_any       <= 1'b0;
      best_valid    <= 1'b0;
      div_cnt       <= '0;
      scene.obj_idx <= '0;
    end else begin
      hit_valid <= 1'b0;
      case (state)
        IDLE: begin
          if (ray_valid) begin
            scene.obj_idx <= '0;
            best_valid    <= 1'b0;
            if (scene.scene_empty) begin
              hit_valid <= 1'b1;
              hit_any   <= 1'b0;
            end else begin
              state <= FETCH;
            end
          end
        end
        // Memory read of the current object
        FETCH: begin
          div_cnt <= '0;
          state   <= DIVIDE;
        end
        DIVIDE: begin
          if (div_cnt == 5'd0) begin
            rem     <= {7'd0, num_abs[24:16]};
            quo     <= num_abs[15:0];
            den     <= den_abs;
            div_neg <= diff[16] ^ dir_ax[15];
            // Also rejects a zero direction component
            div_ok  <= ({7'd0, num_abs[24:16]} < den_abs);
          end else if (trial >= {1'b0, den}) begin
            rem <= 16'(trial - {1'b0, den});
            quo <= {quo[14:0], 1'b1};
          end else begin
            rem <= trial[15:0];
            quo <= {quo[14:0], 1'b0};
          end
          div_cnt <= div_cnt + 1'b1;
          if (div_cnt == 5'd16) begin
            state <= COMPARE;
          end
        end
        COMPARE: begin
          // Strict compare keeps the lower index on a tie
          if (t_hit && (!best_valid || rt_num_pkg::fx_t'(quo) < best_t)) begin
            best_valid <= 1'b1;
            best_t     <= rt_num_pkg::fx_t'(quo);
            best_axis  <= scene.obj.axis;
            best_plane <= scene.obj.pos;
            best_mat   <= scene.obj.mat;
          end
          if (scene.obj_last || scene.obj_idx == SCENE_DEPTH - 1) begin
            state <= FINISH;
          end else begin
            scene.obj_idx <= scene.obj_idx + 1'b1;
            state         <= FETCH;
          end
        end
        FINISH: begin
          hit_valid <= 1'b1;
          hit_any   <= best_valid;
          state     <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == FINISH) begin
      hit_pos  <= pos_calc;
      hit_axis <= best_axis;
      hit_mat  <= best_mat;
    end
  end

endmodule

// File: rtl/ray_reflector.sv
`timescale 1ns/1ps

module ray_reflector (
  input  logic clk,
  input  logic rst,
  input  rt_num_pkg::vec3_t ray_dir,
  input  rt_num_pkg::color_t ray_color,
  input  rt_num_pkg::color_t income_light,
  input  rt_num_pkg::vec3_t hit_pos,
  input  rt_scene_pkg::axis_e hit_axis,
  input  rt_scene_pkg::material_t hit_mat,
  input  logic hit_valid,
  output rt_num_pkg::vec3_t new_dir,
  output rt_num_pkg::vec3_t new_origin,
  output rt_num_pkg::color_t new_color,
  output rt_num_pkg::color_t new_income_light,
  output logic reflect_done
);

  // Per-channel Q8.8 product
  function automatic rt_num_pkg::color_t col_mul(rt_num_pkg::color_t a, rt_num_pkg::color_t b);
    rt_num_pkg::color_t c;
    c.r = rt_num_pkg::fx_mul(a.r, b.r);
    c.g = rt_num_pkg::fx_mul(a.g, b.g);
    c.b = rt_num_pkg::fx_mul(a.b, b.b);
    return c;
  endfunction

  rt_num_pkg::color_t emitted;
  rt_num_pkg::vec3_t mirrored;

  always_comb begin
    emitted  = col_mul(ray_color, hit_mat.emission);
    // Flip the component along the plane normal
    mirrored = ray_dir;
    case (hit_axis)
      rt_scene_pkg::AXIS_X: mirrored.x = -ray_dir.x;
      rt_scene_pkg::AXIS_Y: mirrored.y = -ray_dir.y;
      default: mirrored.z = -ray_dir.z;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      reflect_done <= 1'b0;
    end else begin
      reflect_done <= hit_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (hit_valid) begin
      new_income_light.r <= income_light.r + emitted.r;
      new_income_light.g <= income_light.g + emitted.g;
      new_income_light.b <= income_light.b + emitted.b;
      new_color          <= col_mul(ray_color, hit_mat.albedo);
      new_dir            <= mirrored;
      new_origin         <= hit_pos;
    end
  end

endmodule

// File: rtl/ray_tracer.sv
`timescale 1ns/1ps

module ray_tracer #(
  parameter int SCENE_DEPTH = 8,
  parameter int MAX_BOUNCES = 3
) (
  input  logic clk,
  input  logic rst,
  ray_if.tracer ray,
  scene_if.reader scene
);

  localparam int BW = $clog2(MAX_BOUNCES + 1);

  typedef enum logic [1:0] {IDLE, INTX, REFLECT} tracer_state;

  tracer_state state;

  logic intx_start;
  logic rflx_start;
  logic [BW-1:0] bounce_cnt;

  // Ray being traced
  rt_num_pkg::vec3_t cur_origin;
  rt_num_pkg::vec3_t cur_dir;
  rt_num_pkg::color_t cur_color;
  rt_num_pkg::color_t cur_light;

  rt_num_pkg::vec3_t intx_hit_pos;
  rt_scene_pkg::axis_e intx_hit_axis;
  rt_scene_pkg::material_t intx_hit_mat;
  logic intx_hit_any;
  logic intx_done;

  rt_num_pkg::vec3_t rflx_dir;
  rt_num_pkg::vec3_t rflx_origin;
  rt_num_pkg::color_t rflx_color;
  rt_num_pkg::color_t rflx_light;
  logic rflx_done;

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= IDLE;
      intx_start   <= 1'b0;
      rflx_start   <= 1'b0;
      bounce_cnt   <= '0;
      ray.ray_done <= 1'b0;
    end else begin
      intx_start   <= 1'b0;
      rflx_start   <= 1'b0;
      ray.ray_done <= 1'b0;
      case (state)
        IDLE: begin
          if (ray.ray_valid) begin
            cur_origin <= ray.origin;
            cur_dir    <= ray.dir;
            cur_light  <= '0;
            cur_color  <= '{r: rt_num_pkg::FX_ONE, g: rt_num_pkg::FX_ONE,
                            b: rt_num_pkg::FX_ONE};
            bounce_cnt <= '0;
            intx_start <= 1'b1;
            state      <= INTX;
          end
        end
        INTX: begin
          if (intx_done) begin
            if (intx_hit_any) begin
              rflx_start <= 1'b1;
              state      <= REFLECT;
            end else begin
              // Miss ends the ray with the light gathered so far
              ray.color    <= cur_light;
              ray.ray_done <= 1'b1;
              state        <= IDLE;
            end
          end
        end
        REFLECT: begin
          if (rflx_done) begin
            cur_dir    <= rflx_dir;
            cur_origin <= rflx_origin;
            cur_color  <= rflx_color;
            cur_light  <= rflx_light;
            if (bounce_cnt == BW'(MAX_BOUNCES - 1)) begin
              ray.color    <= rflx_light;
              ray.ray_done <= 1'b1;
              state        <= IDLE;
            end else begin
              bounce_cnt <= bounce_cnt + 1'b1;
              intx_start <= 1'b1;
              state      <= INTX;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  ray_intersector #(
    .SCENE_DEPTH(SCENE_DEPTH)
  ) u_intersector (
    .clk       (clk),
    .rst       (rst),
    .ray_origin(cur_origin),
    .ray_dir   (cur_dir),
    .ray_valid (intx_start),
    .hit_pos   (intx_hit_pos),
    .hit_axis  (intx_hit_axis),
    .hit_mat   (intx_hit_mat),
    .hit_any   (intx_hit_any),
    .hit_valid (intx_done),
    .scene     (scene)
  );

  ray_reflector u_reflector (
    .clk             (clk),
    .rst             (rst),
    .ray_dir         (cur_dir),
    .ray_color       (cur_color),
    .income_light    (cur_light),
    .hit_pos         (intx_hit_pos),
    .hit_axis        (intx_hit_axis),
    .hit_mat         (intx_hit_mat),
    .hit_valid       (rflx_start),
    .new_dir         (rflx_dir),
    .new_origin      (rflx_origin),
    .new_color       (rflx_color),
    .new_income_light(rflx_light),
    .reflect_done    (rflx_done)
  );

endmodule

// File: rtl/rt_top.sv
`timescale 1ns/1ps

module rt_top #(
  parameter int WIDTH       = 8,
  parameter int HEIGHT      = 6,
  parameter int FOCAL       = 4,
  parameter int SCENE_DEPTH = 8,
  parameter int MAX_BOUNCES = 3
) (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  logic load_we,
  input  logic [$clog2(SCENE_DEPTH)-1:0] load_idx,
  input  logic load_last,
  input  rt_scene_pkg::axis_e load_axis,
  input  rt_num_pkg::fx_t load_pos,
  input  rt_num_pkg::color_t load_albedo,
  input  rt_num_pkg::color_t load_emission,
  output logic pix_valid,
  output logic [$clog2(WIDTH)-1:0] pix_h,
  output logic [$clog2(HEIGHT)-1:0] pix_v,
  output rt_num_pkg::color_t pix_color,
  output logic frame_done
);

  ray_if u_ray_if ();
  scene_if #(.SCENE_DEPTH(SCENE_DEPTH)) u_scene_if ();

  rt_scene_pkg::object_t load_obj;

  always_comb begin
    load_obj.axis         = load_axis;
    load_obj.pos          = load_pos;
    load_obj.mat.albedo   = load_albedo;
    load_obj.mat.emission = load_emission;
  end

  scene_buffer #(
    .SCENE_DEPTH(SCENE_DEPTH)
  ) u_scene_buffer (
    .clk      (clk),
    .rst      (rst),
    .load_we  (load_we),
    .load_idx (load_idx),
    .load_last(load_last),
    .load_obj (load_obj),
    .scene    (u_scene_if.mem)
  );

  pixel_ray_gen #(
    .WIDTH (WIDTH),
    .HEIGHT(HEIGHT),
    .FOCAL (FOCAL)
  ) u_pixel_ray_gen (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .ray       (u_ray_if.gen),
    .pix_valid (pix_valid),
    .pix_h     (pix_h),
    .pix_v     (pix_v),
    .pix_color (pix_color),
    .frame_done(frame_done)
  );

  ray_tracer #(
    .SCENE_DEPTH(SCENE_DEPTH),
    .MAX_BOUNCES(MAX_BOUNCES)
  ) u_ray_tracer (
    .clk  (clk),
    .rst  (rst),
    .ray  (u_ray_if.tracer),
    .scene(u_scene_if.reader)
  );

endmodule

// File: tb/tb_rt_top.sv
`timescale 1ns/1ps

module tb_rt_top;

  localparam int WIDTH         = 8;
  localparam int HEIGHT        = 6;
  localparam int FOCAL         = 4;
  localparam int SCENE_DEPTH   = 8;
  localparam int MAX_BOUNCES   = 3;
  localparam int NUM_PIX       = WIDTH * HEIGHT;
  localparam int FRAME_TIMEOUT = 40000;

  logic clk;
  logic rst;
  logic start;
  logic load_we;
  logic [$clog2(SCENE_DEPTH)-1:0] load_idx;
  logic load_last;
  rt_scene_pkg::axis_e load_axis;
  rt_num_pkg::fx_t load_pos;
  rt_num_pkg::color_t load_albedo;
  rt_num_pkg::color_t load_emission;
  logic pix_valid;
  logic [$clog2(WIDTH)-1:0] pix_h;
  logic [$clog2(HEIGHT)-1:0] pix_v;
  rt_num_pkg::color_t pix_color;
  logic frame_done;

  // Copy of the loaded scene for the reference model
  rt_scene_pkg::axis_e sc_axis [SCENE_DEPTH];
  rt_num_pkg::fx_t sc_pos [SCENE_DEPTH];
  rt_num_pkg::color_t sc_alb [SCENE_DEPTH];
  rt_num_pkg::color_t sc_emi [SCENE_DEPTH];
  int n_obj;

  bit frame_active;
  bit hung;
  int ctl_errs;
  int exp_idx = 0;
  int frames_seen = 0;
  int pix_checked = 0;
  int mon_errs = 0;

  rt_top #(
    .WIDTH      (WIDTH),
    .HEIGHT     (HEIGHT),
    .FOCAL      (FOCAL),
    .SCENE_DEPTH(SCENE_DEPTH),
    .MAX_BOUNCES(MAX_BOUNCES)
  ) u_dut (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .load_we      (load_we),
    .load_idx     (load_idx),
    .load_last    (load_last),
    .load_axis    (load_axis),
    .load_pos     (load_pos),
    .load_albedo  (load_albedo),
    .load_emission(load_emission),
    .pix_valid    (pix_valid),
    .pix_h        (pix_h),
    .pix_v        (pix_v),
    .pix_color    (pix_color),
    .frame_done   (frame_done)
  );

  always #4 clk = ~clk;

  // Q8.8 product, truncated back to one word
  function automatic rt_num_pkg::fx_t q88_mul(int a, int b);
    int p;
    p = a * b;
    return rt_num_pkg::fx_t'(p >>> rt_num_pkg::FRAC_BITS);
  endfunction

  function automatic rt_num_pkg::color_t rand_color();
    rt_num_pkg::color_t c;
    c.r = rt_num_pkg::fx_t'($urandom_range(256, 0));
    c.g = rt_num_pkg::fx_t'($urandom_range(256, 0));
    c.b = rt_num_pkg::fx_t'($urandom_range(256, 0));
    return c;
  endfunction

  // Expected pixel color, components indexed x,y,z and r,g,b
  function automatic rt_num_pkg::color_t expected_color(int h, int v);
    rt_num_pkg::fx_t org [3];
    rt_num_pkg::fx_t dir [3];
    rt_num_pkg::fx_t col [3];
    rt_num_pkg::fx_t light [3];
    rt_num_pkg::fx_t alb [3];
    rt_num_pkg::fx_t emi [3];
    rt_num_pkg::color_t res;
    int a;
    int t;
    int best;
    int best_t;
    bit done;
    for (int c = 0; c < 3; c++) begin
      org[c]   = '0;
      col[c]   = 16'sd256;
      light[c] = '0;
    end
    dir[0] = rt_num_pkg::fx_t'((h - WIDTH / 2) * 256);
    dir[1] = rt_num_pkg::fx_t'((v - HEIGHT / 2) * 256);
    dir[2] = rt_num_pkg::fx_t'(FOCAL * 256);
    done = 1'b0;
    for (int b = 0; b < MAX_BOUNCES && !done; b++) begin
      best   = -1;
      best_t = 0;
      for (int i = 0; i < n_obj; i++) begin
        a = int'(sc_axis[i]);
        if (dir[a] != 0) begin
          // SV division truncates toward zero
          t = ((int'(sc_pos[i]) - int'(org[a])) * 256) / int'(dir[a]);
          if (t > 0 && t < 32768 && (best < 0 || t < best_t)) begin
            best   = i;
            best_t = t;
          end
        end
      end
      if (best < 0) begin
        done = 1'b1;
      end else begin
        a = int'(sc_axis[best]);
        for (int c = 0; c < 3; c++) begin
          org[c] = org[c] + q88_mul(best_t, dir[c]);
        end
        org[a] = sc_pos[best];
        dir[a] = -dir[a];
        alb[0] = sc_alb[best].r;
        alb[1] = sc_alb[best].g;
        alb[2] = sc_alb[best].b;
        emi[0] = sc_emi[best].r;
        emi[1] = sc_emi[best].g;
        emi[2] = sc_emi[best].b;
        // Emission is weighted by the color before attenuation
        for (int c = 0; c < 3; c++) begin
          light[c] = light[c] + q88_mul(col[c], emi[c]);
          col[c]   = q88_mul(col[c], alb[c]);
        end
      end
    end
    res.r = light[0];
    res.g = light[1];
    res.b = light[2];
    return res;
  endfunction

  // Pixel checker, samples away from the driving edge
  always @(negedge clk) begin : monitor
    rt_num_pkg::color_t exp_c;
    int eh;
    int ev;
    if (!frame_active) begin
      exp_idx = 0;
    end
    if (!rst) begin
      if (pix_valid) begin
        if (!frame_active) begin
          $display("Error at %0d ns: pixel output with no frame running", $time);
          mon_errs++;
        end else if (exp_idx >= NUM_PIX) begin
          $display("Error at %0d ns: pixel output after the last pixel", $time);
          mon_errs++;
        end else begin
          eh    = exp_idx % WIDTH;
          ev    = exp_idx / WIDTH;
          exp_c = expected_color(eh, ev);
          if (int'(pix_h) != eh || int'(pix_v) != ev) begin
            $display("Error at %0d ns: pixel at (%0d,%0d), expected (%0d,%0d)",
                     $time, pix_h, pix_v, eh, ev);
            mon_errs++;
          end
          if (pix_color != exp_c) begin
            $display("Error at %0d ns: pixel (%0d,%0d) color %0d %0d %0d, expected %0d %0d %0d",
                     $time, eh, ev, pix_color.r, pix_color.g, pix_color.b,
                     exp_c.r, exp_c.g, exp_c.b);
            mon_errs++;
          end
          if (frame_done != (exp_idx == NUM_PIX - 1)) begin
            $display("Error at %0d ns: frame_done is %0b at pixel %0d", $time, frame_done, exp_idx);
            mon_errs++;
          end
          if (frame_done) begin
            frames_seen++;
          end
          exp_idx++;
          pix_checked++;
        end
      end else if (frame_done) begin
        $display("Error at %0d ns: frame_done without a pixel", $time);
        mon_errs++;
      end
    end
  end

  task automatic apply_reset();
    rst   <= 1'b1;
    n_obj  = 0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic load_object(int idx, rt_scene_pkg::axis_e axis, rt_num_pkg::fx_t pos,
                             rt_num_pkg::color_t alb, rt_num_pkg::color_t emi, bit last);
    @(posedge clk);
    load_we       <= 1'b1;
    load_idx      <= idx[$clog2(SCENE_DEPTH)-1:0];
    load_last     <= last;
    load_axis     <= axis;
    load_pos      <= pos;
    load_albedo   <= alb;
    load_emission <= emi;
    sc_axis[idx]   = axis;
    sc_pos[idx]    = pos;
    sc_alb[idx]    = alb;
    sc_emi[idx]    = emi;
    if (last) begin
      n_obj = idx + 1;
    end
    @(posedge clk);
    load_we   <= 1'b0;
    load_last <= 1'b0;
  endtask

  task automatic start_frame();
    @(posedge clk);
    frame_active = 1'b1;
    start       <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  // Waits for frame_done; optionally pulses start once mid-frame
  task automatic finish_frame(bit poke_start);
    int base;
    int cycles;
    bit poked;
    base   = frames_seen;
    cycles = 0;
    poked  = 1'b0;
    while (frames_seen == base && cycles < FRAME_TIMEOUT) begin
      @(posedge clk);
      cycles++;
      if (poke_start && !poked && exp_idx >= 5) begin
        start <= 1'b1;
        poked  = 1'b1;
      end else begin
        start <= 1'b0;
      end
    end
    if (frames_seen == base) begin
      $display("Timeout: no frame_done within %0d cycles, the DUT seems to hang", FRAME_TIMEOUT);
      hung = 1'b1;
    end else if (exp_idx != NUM_PIX) begin
      $display("Error at %0d ns: frame ended after %0d pixels, expected %0d",
               $time, exp_idx, NUM_PIX);
      ctl_errs++;
    end
    start       <= 1'b0;
    frame_active = 1'b0;
  endtask

  task automatic render_frame(bit poke_start);
    if (hung) begin
      return;
    end
    start_frame();
    finish_frame(poke_start);
    // Stray pixels in the gap are caught by the monitor
    repeat (50) @(posedge clk);
  endtask

  task automatic reset_mid_frame();
    int cycles;
    if (hung) begin
      return;
    end
    start_frame();
    cycles = 0;
    while (exp_idx < 10 && cycles < FRAME_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    frame_active = 1'b0;
    if (cycles >= FRAME_TIMEOUT) begin
      $display("Timeout: frame stalled before pixel 10, the DUT seems to hang");
      hung = 1'b1;
      return;
    end
    apply_reset();
    // Much longer than one pixel, so a surviving frame would show up
    repeat (2000) @(posedge clk);
  endtask

  initial begin
    clk           = 1'b0;
    rst           = 1'b1;
    start         = 1'b0;
    load_we       = 1'b0;
    load_idx      = '0;
    load_last     = 1'b0;
    load_axis     = rt_scene_pkg::AXIS_X;
    load_pos      = '0;
    load_albedo   = '0;
    load_emission = '0;
    frame_active  = 1'b0;
    hung          = 1'b0;
    ctl_errs      = 0;
    n_obj         = 0;
    void'($urandom(32'hac89));
    apply_reset();

    // Nothing loaded
    render_frame(1'b0);
    // Single plane behind the camera
    load_object(0, rt_scene_pkg::AXIS_Z, -16'sd512, rand_color(), rand_color(), 1'b1);
    render_frame(1'b0);
    // Emissive back wall at a random depth
    load_object(0, rt_scene_pkg::AXIS_Z,
                rt_num_pkg::fx_t'(($urandom % 12 + 2) * 256 + $urandom % 256),
                rand_color(), rand_color(), 1'b1);
    render_frame(1'b0);
    // Far wall, then a near wall and its duplicate
    load_object(0, rt_scene_pkg::AXIS_Z, 16'sd3072, rand_color(), rand_color(), 1'b0);
    load_object(1, rt_scene_pkg::AXIS_Z, 16'sd1280, rand_color(), rand_color(), 1'b0);
    load_object(2, rt_scene_pkg::AXIS_Z, 16'sd1280, rand_color(), rand_color(), 1'b1);
    render_frame(1'b0);
    // Facing x mirrors in front of a back wall
    load_object(0, rt_scene_pkg::AXIS_X, 16'sd768, rand_color(), rand_color(), 1'b0);
    load_object(1, rt_scene_pkg::AXIS_X, -16'sd768, rand_color(), rand_color(), 1'b0);
    load_object(2, rt_scene_pkg::AXIS_Z, 16'sd2560, rand_color(), rand_color(), 1'b1);
    render_frame(1'b0);

    reset_mid_frame();
    load_object(0, rt_scene_pkg::AXIS_Y, 16'sd512, rand_color(), rand_color(), 1'b0);
    load_object(1, rt_scene_pkg::AXIS_Z, 16'sd2304, rand_color(), rand_color(), 1'b1);
    render_frame(1'b1);

    $display("Summary: %0d pixels checked, %0d monitor errors, %0d control errors, hang %0b",
             pix_checked, mon_errs, ctl_errs, hung);
    if (mon_errs == 0 && ctl_errs == 0 && !hung) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: sim.f
rtl/rt_num_pkg.sv
rtl/rt_scene_pkg.sv
rtl/rt_ifs.sv
rtl/scene_buffer.sv
rtl/pixel_ray_gen.sv
rtl/ray_intersector.sv
rtl/ray_reflector.sv
rtl/ray_tracer.sv
rtl/rt_top.sv
tb/tb_rt_top.sv

// File: Makefile
# Verilator build for the ray tracer testbench
VERILATOR ?= verilator
TOP       ?= tb_rt_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
SOURCES   := $(wildcard rtl/*.sv tb/*.sv)
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
